// File: common/lvda_pkg.sv
package lvda_pkg;

    // ##############################
    // Widths
    // ##############################

    localparam int ADDR_W = 9;    // Processor I/O address word
    localparam int DATA_W = 26;   // Computer data word and the BRD line count
    localparam int INTR_N = 7;    // Interrupt lines
    localparam int DIN_N  = 24;   // Discrete input channels

    localparam int IDX_W  = 5;    // Bit index and channel field width
    localparam int SPAN_W = 3;    // Sample span field width

    // ##############################
    // Address word
    // ##############################

    typedef enum logic [2:0] {
        BUF_LOAD      = 3'd0,
        BUF_SET_BIT   = 3'd1,
        BUF_CLR_BIT   = 3'd2,
        BUF_READ      = 3'd3,
        INT_MASK_LOAD = 3'd4,
        INT_CLEAR     = 3'd5,
        INT_READ      = 3'd6,
        RESERVED      = 3'd7
    } pio_op_e;

    // Register commands act on the buffer or the interrupt unit
    typedef struct packed {
        logic             space;        // 0 in this view
        pio_op_e          op;
        logic [IDX_W-1:0] bit_index;
    } pio_reg_view_t;

    // Sample commands read a window of discrete channels
    typedef struct packed {
        logic              space;       // 1 in this view
        logic [SPAN_W-1:0] span;        // Window width minus one
        logic [IDX_W-1:0]  channel;     // Lowest channel of the window
    } pio_sample_view_t;

    typedef union packed {
        pio_reg_view_t    regs;
        pio_sample_view_t sample;
    } pio_addr_u;

    // ##############################
    // Pipeline
    // ##############################

    typedef struct packed {
        logic              valid;
        logic              is_sample;
        pio_op_e           op;
        logic [IDX_W-1:0]  bit_index;
        logic [IDX_W-1:0]  channel;
        logic [SPAN_W-1:0] span;
        logic [DATA_W-1:0] wdata;
        logic              error;
    } pio_cmd_t;

    // Reply word of one execute unit that stays zero while the unit is not answering
    typedef logic [DATA_W-1:0] unit_reply_t;

endpackage

// File: decode/pio_decode.sv
module pio_decode #(
    parameter int ADDR_W = lvda_pkg::ADDR_W,
    parameter int DATA_W = lvda_pkg::DATA_W
) (
    input  logic                sim_clk,
    input  logic                reset,
    input  logic                pio_strobe,
    input  logic [ADDR_W-1:0]   pio_addr,
    input  logic [DATA_W-1:0]   pio_wdata,
    output lvda_pkg::pio_cmd_t  pio_cmd
);

    lvda_pkg::pio_addr_u addr_word;
    lvda_pkg::pio_cmd_t  cmd_d;

    assign addr_word = pio_addr;

    always_comb begin
        cmd_d           = '0;
        cmd_d.valid     = pio_strobe;
        cmd_d.is_sample = addr_word.sample.space;
        cmd_d.wdata     = pio_wdata;
        if (addr_word.sample.space) begin
            // The op field has no meaning in the sample view and stays at BUF_LOAD
            cmd_d.op      = lvda_pkg::BUF_LOAD;
            cmd_d.span    = addr_word.sample.span;
            cmd_d.channel = addr_word.sample.channel;
        end else begin
            cmd_d.op        = addr_word.regs.op;
            cmd_d.bit_index = addr_word.regs.bit_index;
            case (addr_word.regs.op)
                lvda_pkg::RESERVED: cmd_d.error = 1'b1;
                lvda_pkg::BUF_SET_BIT,
                lvda_pkg::BUF_CLR_BIT: cmd_d.error = (addr_word.regs.bit_index >= DATA_W);
                default: cmd_d.error = 1'b0;
            endcase
        end
    end

    // One registered command per strobe
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            pio_cmd <= '0;
        end else begin
            pio_cmd <= cmd_d;
        end
    end

    a_reserved_error : assert property (
        @(posedge sim_clk) disable iff (reset)
        pio_strobe && !addr_word.regs.space && addr_word.regs.op == lvda_pkg::RESERVED
        |=> pio_cmd.valid && pio_cmd.error
    ) else $error("RESERVED op reached the execute stage without its error flag");

endmodule

// File: execute/buffer_regs.sv
module buffer_regs #(
    parameter int DATA_W = lvda_pkg::DATA_W
) (
    input  logic                  sim_clk,
    input  logic                  reset,
    input  lvda_pkg::pio_cmd_t    pio_cmd,
    output logic [DATA_W-1:0]     brd,
    output lvda_pkg::unit_reply_t buf_reply
);

    logic              reg_cmd;
    logic              buf_write;
    logic              buf_read;
    logic [DATA_W-1:0] bit_mask;

    // Erroneous commands never reach the buffer
    assign reg_cmd  = pio_cmd.valid && !pio_cmd.is_sample && !pio_cmd.error;
    assign buf_read = reg_cmd && pio_cmd.op == lvda_pkg::BUF_READ;
    assign bit_mask = DATA_W'(1) << pio_cmd.bit_index;

    always_comb begin
        case (pio_cmd.op)
            lvda_pkg::BUF_LOAD,
            lvda_pkg::BUF_SET_BIT,
            lvda_pkg::BUF_CLR_BIT: buf_write = reg_cmd;
            default:               buf_write = 1'b0;
        endcase
    end

    // ##############################
    // Output buffer
    // ##############################

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            brd <= '0;
        end else if (buf_write) begin
            case (pio_cmd.op)
                lvda_pkg::BUF_SET_BIT: brd <= brd | bit_mask;
                lvda_pkg::BUF_CLR_BIT: brd <= brd & ~bit_mask;
                default:               brd <= pio_cmd.wdata;   // BUF_LOAD
            endcase
        end
    end

    // Read returns the buffer as it stood before this command
    always_ff @(posedge sim_clk) begin
        if (reset) begin
            buf_reply <= '0;
        end else begin
            buf_reply <= buf_read ? brd : '0;
        end
    end

    a_brd_stable : assert property (
        @(posedge sim_clk) disable iff (reset)
        !$past(reset) && !$past(buf_write) |-> $stable(brd)
    ) else $error("brd changed without a buffer write command");

endmodule

// File: execute/interrupt_regs.sv
module interrupt_regs (
    input  logic                          sim_clk,
    input  logic                          reset,
    input  logic [lvda_pkg::INTR_N-1:0]   intr,
    input  lvda_pkg::pio_cmd_t            pio_cmd,
    output logic                          intc,
    output lvda_pkg::unit_reply_t         int_reply
);

    localparam int N = lvda_pkg::INTR_N;

    logic [N-1:0] intr_meta;
    logic [N-1:0] intr_sync;
    logic [N-1:0] intr_last;   // Previous synced level for edge detection
    logic [N-1:0] intr_rise;
    logic [N-1:0] pending;
    logic [N-1:0] mask;        // 1 blocks the line
    logic [N-1:0] clear_bits;
    logic         reg_cmd;

    assign reg_cmd   = pio_cmd.valid && !pio_cmd.is_sample && !pio_cmd.error;
    assign intr_rise = intr_sync & ~intr_last;

    always_comb begin
        clear_bits = '0;
        if (reg_cmd && pio_cmd.op == lvda_pkg::INT_CLEAR) begin
            clear_bits = pio_cmd.wdata[N-1:0];
        end
    end

    // ##############################
    // Synchronizer and edge detect
    // ##############################

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            intr_meta <= '0;
            intr_sync <= '0;
            intr_last <= '0;
        end else begin
            intr_meta <= intr;
            intr_sync <= intr_meta;
            intr_last <= intr_sync;
        end
    end

    // ##############################
    // Pending, mask and request
    // ##############################

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            pending   <= '0;
            mask      <= '0;
            intc      <= 1'b0;
            int_reply <= '0;
        end else begin
            pending <= (pending & ~clear_bits) | intr_rise;  // A new edge beats the clear
            if (reg_cmd && pio_cmd.op == lvda_pkg::INT_MASK_LOAD) begin
                mask <= pio_cmd.wdata[N-1:0];
            end
            intc <= |(pending & ~mask);
            if (reg_cmd && pio_cmd.op == lvda_pkg::INT_READ) begin
                int_reply <= lvda_pkg::unit_reply_t'(pending);
            end else begin
                int_reply <= '0;
            end
        end
    end

    a_intc_masked : assert property (
        @(posedge sim_clk) disable iff (reset)
        (pending & ~mask) == '0 |=> !intc
    ) else $error("intc raised while every pending line was masked");

endmodule

// File: execute/discrete_sampler.sv
module discrete_sampler (
    input  logic                         sim_clk,
    input  logic                         reset,
    input  logic [lvda_pkg::DIN_N-1:0]   din,
    input  lvda_pkg::pio_cmd_t           pio_cmd,
    output lvda_pkg::unit_reply_t        sample_reply
);

    localparam int WIN_W = 1 << lvda_pkg::SPAN_W;   // Widest window of 8 channels

    logic [lvda_pkg::DIN_N-1:0] din_meta;
    logic [lvda_pkg::DIN_N-1:0] din_sync;
    logic [lvda_pkg::DIN_N-1:0] shifted;
    logic [WIN_W-1:0]           window_mask;
    logic                       sample_cmd;

    assign sample_cmd = pio_cmd.valid && pio_cmd.is_sample && !pio_cmd.error;

    // Channels past the top of the vector shift in as zero
    assign shifted     = din_sync >> pio_cmd.channel;
    assign window_mask = ~({WIN_W{1'b1}} << (pio_cmd.span + 1));

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            din_meta <= '0;
            din_sync <= '0;
        end else begin
            din_meta <= din;
            din_sync <= din_meta;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            sample_reply <= '0;
        end else if (sample_cmd) begin
            sample_reply <= lvda_pkg::unit_reply_t'(shifted[WIN_W-1:0] & window_mask);
        end else begin
            sample_reply <= '0;
        end
    end

endmodule

// File: logic/pio_result.sv
module pio_result #(
    parameter int DATA_W = lvda_pkg::DATA_W
) (
    input  logic                  sim_clk,
    input  logic                  reset,
    input  lvda_pkg::pio_cmd_t    pio_cmd,
    input  lvda_pkg::unit_reply_t buf_reply,
    input  lvda_pkg::unit_reply_t int_reply,
    input  lvda_pkg::unit_reply_t sample_reply,
    output logic                  data_valid,
    output logic [DATA_W-1:0]     rdata,
    output logic                  error
);

    logic valid_q;   // Command flags aligned with the unit replies
    logic error_q;

    always_ff @(posedge sim_clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            error_q    <= 1'b0;
            data_valid <= 1'b0;
            error      <= 1'b0;
            rdata      <= '0;
        end else begin
            valid_q    <= pio_cmd.valid;
            error_q    <= pio_cmd.valid && pio_cmd.error;
            data_valid <= valid_q;
            error      <= error_q;
            rdata      <= buf_reply | int_reply | sample_reply;  // Idle units answer zero
        end
    end

    a_one_reply : assert property (
        @(posedge sim_clk) disable iff (reset)
        $onehot0({buf_reply != '0, int_reply != '0, sample_reply != '0})
    ) else $error("More than one execute unit answered in the same cycle");

endmodule

// File: logic/lvda_top.sv
module lvda_top #(
    parameter int ADDR_W = lvda_pkg::ADDR_W,
    parameter int DATA_W = lvda_pkg::DATA_W
) (
    input  logic                          sim_clk,
    input  logic                          reset,
    input  logic                          pio_strobe,
    input  lvda_pkg::pio_addr_u           pio_addr,
    input  logic [DATA_W-1:0]             pio_wdata,
    input  logic [lvda_pkg::DIN_N-1:0]    din,
    input  logic [lvda_pkg::INTR_N-1:0]   intr,
    output logic [DATA_W-1:0]             brd,
    output logic                          intc,
    output logic                          data_valid,
    output logic [DATA_W-1:0]             rdata,
    output logic                          error
);

    lvda_pkg::pio_cmd_t    pio_cmd;
    lvda_pkg::unit_reply_t buf_reply;
    lvda_pkg::unit_reply_t int_reply;
    lvda_pkg::unit_reply_t sample_reply;

    pio_decode #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_decode (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .pio_strobe (pio_strobe),
        .pio_addr   (pio_addr),
        .pio_wdata  (pio_wdata),
        .pio_cmd    (pio_cmd)
    );

    buffer_regs #(.DATA_W(DATA_W)) u_buffer (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .pio_cmd   (pio_cmd),
        .brd       (brd),
        .buf_reply (buf_reply)
    );

    interrupt_regs u_interrupt (
        .sim_clk   (sim_clk),
        .reset     (reset),
        .intr      (intr),
        .pio_cmd   (pio_cmd),
        .intc      (intc),
        .int_reply (int_reply)
    );

    discrete_sampler u_sampler (
        .sim_clk      (sim_clk),
        .reset        (reset),
        .din          (din),
        .pio_cmd      (pio_cmd),
        .sample_reply (sample_reply)
    );

    pio_result #(.DATA_W(DATA_W)) u_result (
        .sim_clk      (sim_clk),
        .reset        (reset),
        .pio_cmd      (pio_cmd),
        .buf_reply    (buf_reply),
        .int_reply    (int_reply),
        .sample_reply (sample_reply),
        .data_valid   (data_valid),
        .rdata        (rdata),
        .error        (error)
    );

endmodule

// File: verification/lvda_tb.sv
module lvda_tb;

    localparam int N_DIRECT    = 17;
    localparam int N_SAMPLE    = 48;   // Twelve batches of four sample commands
    localparam int N_RANDOM    = 160;
    localparam int CYCLE_LIMIT = 4 * (N_DIRECT + N_SAMPLE + N_RANDOM) + 200;

    typedef struct packed {
        logic                        error;
        logic [lvda_pkg::DATA_W-1:0] data;
    } reply_t;

    logic                          sim_clk    = 1'b0;
    logic                          reset      = 1'b1;
    logic                          pio_strobe = 1'b0;
    lvda_pkg::pio_addr_u           pio_addr   = '0;
    logic [lvda_pkg::DATA_W-1:0]   pio_wdata  = '0;
    logic [lvda_pkg::DIN_N-1:0]    din        = '0;
    logic [lvda_pkg::INTR_N-1:0]   intr       = '0;
    logic [lvda_pkg::DATA_W-1:0]   brd;
    logic                          intc;
    logic                          data_valid;
    logic [lvda_pkg::DATA_W-1:0]   rdata;
    logic                          error;

    // ##############################
    // Reference model
    // ##############################

    logic [lvda_pkg::DATA_W-1:0]   model_buf     = '0;
    logic [lvda_pkg::INTR_N-1:0]   model_pending = '0;
    logic [lvda_pkg::INTR_N-1:0]   model_mask    = '0;
    logic [lvda_pkg::DATA_W-1:0]   buf_d1        = '0;
    logic [lvda_pkg::DATA_W-1:0]   buf_d2        = '0;   // Model buffer as brd shows it
    reply_t                        exp_q[$];
    reply_t                        exp_reply     = '0;
    logic                          intc_chk      = 1'b0;
    logic                          exp_intc;
    logic                          unmasked_rise;
    integer                        seed;
    logic [31:0]                   r;
    logic [31:0]                   w;
    int                            errors  = 0;
    int                            issued  = 0;
    int                            replies = 0;
    int                            cycles  = 0;
    int                            n;

    assign exp_intc      = |(model_pending & ~model_mask);
    assign unmasked_rise = |(intr & ~model_mask);

    lvda_top dut (
        .sim_clk    (sim_clk),
        .reset      (reset),
        .pio_strobe (pio_strobe),
        .pio_addr   (pio_addr),
        .pio_wdata  (pio_wdata),
        .din        (din),
        .intr       (intr),
        .brd        (brd),
        .intc       (intc),
        .data_valid (data_valid),
        .rdata      (rdata),
        .error      (error)
    );

    always #20 sim_clk = ~sim_clk;

    // Buffer writes show on brd one edge after the command is registered
    always @(posedge sim_clk) begin
        buf_d1 <= model_buf;
        buf_d2 <= buf_d1;
    end

    always @(negedge sim_clk) begin
        if (!reset && data_valid) begin
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("%0t: a reply arrived with no command outstanding", $time);
            end else begin
                exp_reply = exp_q.pop_front();
                replies   = replies + 1;
            end
        end
    end

    always @(posedge sim_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("%0t: the run did not finish within %0d cycles", $time, CYCLE_LIMIT);
            $display("Summary: %0d commands, %0d replies, %0d errors, timed out",
                     issued, replies, errors + 1);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ##############################
    // Checks
    // ##############################

    a_reset_idle : assert property (@(posedge sim_clk) disable iff (reset)
        $fell(reset) |-> !data_valid && !error && !intc && brd == '0)
    else begin
        errors = errors + 1;
        $display("%0t: outputs were not idle after reset", $time);
    end

    a_latency : assert property (@(posedge sim_clk) disable iff (reset)
        data_valid == $past(pio_strobe, 3))
    else begin
        errors = errors + 1;
        $display("[ERROR] %0t data_valid expected %b actual %b",
                 $time, !$sampled(data_valid), $sampled(data_valid));
    end

    a_rdata : assert property (@(posedge sim_clk) disable iff (reset)
        data_valid |-> rdata == exp_reply.data)
    else begin
        errors = errors + 1;
        $display("[ERROR] %0t rdata expected %h actual %h",
                 $time, $sampled(exp_reply.data), $sampled(rdata));
    end

    a_error : assert property (@(posedge sim_clk) disable iff (reset)
        data_valid |-> error == exp_reply.error)
    else begin
        errors = errors + 1;
        $display("[ERROR] %0t error expected %b actual %b",
                 $time, $sampled(exp_reply.error), $sampled(error));
    end

    a_brd : assert property (@(posedge sim_clk) disable iff (reset) brd == buf_d2)
    else begin
        errors = errors + 1;
        $display("[ERROR] %0t brd expected %h actual %h", $time, $sampled(buf_d2), $sampled(brd));
    end

    a_intc_rise : assert property (@(posedge sim_clk) disable iff (reset)
        $rose(unmasked_rise) |-> ##[1:4] intc)
    else begin
        errors = errors + 1;
        $display("%0t: intc did not rise within 4 cycles of an unmasked interrupt", $time);
    end

    a_intc : assert property (@(posedge sim_clk) disable iff (reset)
        intc_chk |-> intc == exp_intc)
    else begin
        errors = errors + 1;
        $display("[ERROR] %0t intc expected %b actual %b",
                 $time, $sampled(exp_intc), $sampled(intc));
    end

    function automatic logic [8:0] reg_addr(input lvda_pkg::pio_op_e op, input logic [4:0] idx);
        return {1'b0, op, idx};
    endfunction

    // Works out the reply from the decode rules and then drives one strobe
    task automatic issue_cmd(input logic [8:0] addr, input logic [lvda_pkg::DATA_W-1:0] wdata);
        reply_t     exp;
        logic [2:0] op;
        int         idx;
        int         i;
        exp = '0;
        op  = addr[7:5];
        idx = addr[4:0];
        if (addr[8]) begin
            for (i = 0; i <= op; i++) begin   // op bits hold the span here
                if (idx + i < lvda_pkg::DIN_N) begin
                    exp.data[i] = din[idx + i];
                end
            end
        end else begin
            case (op)
                lvda_pkg::BUF_LOAD:      model_buf = wdata;
                lvda_pkg::BUF_SET_BIT,
                lvda_pkg::BUF_CLR_BIT: begin
                    if (idx >= lvda_pkg::DATA_W) begin
                        exp.error = 1'b1;
                    end else begin
                        model_buf[idx] = (op == lvda_pkg::BUF_SET_BIT);
                    end
                end
                lvda_pkg::BUF_READ:      exp.data = model_buf;
                lvda_pkg::INT_MASK_LOAD: model_mask = wdata[lvda_pkg::INTR_N-1:0];
                lvda_pkg::INT_CLEAR: begin
                    model_pending = model_pending & ~wdata[lvda_pkg::INTR_N-1:0];
                end
                lvda_pkg::INT_READ:      exp.data = lvda_pkg::DATA_W'(model_pending);
                default:                 exp.error = 1'b1;
            endcase
        end
        exp_q.push_back(exp);
        issued     = issued + 1;
        pio_strobe = 1'b1;
        pio_addr   = addr;
        pio_wdata  = wdata;
        @(negedge sim_clk);
        pio_strobe = 1'b0;
    endtask

    task automatic pulse_intr(input int line);
        intr[line]          = 1'b1;
        model_pending[line] = 1'b1;
        repeat (3) @(negedge sim_clk);
        intr[line] = 1'b0;
    endtask

    task automatic check_intc_settled();
        repeat (6) @(negedge sim_clk);
        intc_chk = 1'b1;
        @(negedge sim_clk);
        intc_chk = 1'b0;
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        seed = 32'h0bb7ef6b;
        repeat (2) @(posedge sim_clk);
        @(negedge sim_clk);
        reset = 1'b0;

        issue_cmd(reg_addr(lvda_pkg::BUF_READ, 5'd0), '0);
        issue_cmd(reg_addr(lvda_pkg::BUF_LOAD, 5'd0), 26'h2a5a5a5);
        issue_cmd(reg_addr(lvda_pkg::BUF_READ, 5'd0), '0);
        issue_cmd(reg_addr(lvda_pkg::BUF_SET_BIT, 5'd1), '0);
        issue_cmd(reg_addr(lvda_pkg::BUF_CLR_BIT, 5'd0), '0);
        issue_cmd(reg_addr(lvda_pkg::BUF_CLR_BIT, 5'd25), '0);
        issue_cmd(reg_addr(lvda_pkg::BUF_SET_BIT, 5'd26), '0);   // Index past the buffer
        issue_cmd(reg_addr(lvda_pkg::BUF_CLR_BIT, 5'd31), '0);
        issue_cmd(reg_addr(lvda_pkg::RESERVED, 5'd0), 26'h3ffffff);
        issue_cmd(reg_addr(lvda_pkg::BUF_READ, 5'd0), '0);

        issue_cmd(reg_addr(lvda_pkg::INT_MASK_LOAD, 5'd0), '0);
        pulse_intr(2);
        check_intc_settled();
        issue_cmd(reg_addr(lvda_pkg::INT_READ, 5'd0), '0);
        issue_cmd(reg_addr(lvda_pkg::INT_CLEAR, 5'd0), 26'h4);
        check_intc_settled();
        // Line 5 is masked so it stays pending with intc low
        issue_cmd(reg_addr(lvda_pkg::INT_MASK_LOAD, 5'd0), 26'h20);
        pulse_intr(5);
        check_intc_settled();
        issue_cmd(reg_addr(lvda_pkg::INT_READ, 5'd0), '0);
        issue_cmd(reg_addr(lvda_pkg::INT_CLEAR, 5'd0), 26'h7f);
        issue_cmd(reg_addr(lvda_pkg::INT_MASK_LOAD, 5'd0), '0);

        for (n = 0; n < N_SAMPLE / 4; n++) begin
            r   = $random(seed);
            din = r[lvda_pkg::DIN_N-1:0];
            repeat (3) @(negedge sim_clk);   // Past the input synchronizer
            repeat (4) begin
                r = $random(seed);
                issue_cmd({1'b1, r[7:0]}, r[31:6]);
            end
        end

        for (n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            w = $random(seed);
            issue_cmd(r[8:0], w[lvda_pkg::DATA_W-1:0]);
        end

        while (exp_q.size() != 0) begin
            @(negedge sim_clk);
        end
        repeat (4) @(negedge sim_clk);
        $display("Summary: %0d commands, %0d replies, %0d errors", issued, replies, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
common/lvda_pkg.sv
decode/pio_decode.sv
execute/buffer_regs.sv
execute/interrupt_regs.sv
execute/discrete_sampler.sv
logic/pio_result.sv
logic/lvda_top.sv
verification/lvda_tb.sv

// File: Bender.yml
package:
  name: lvda_pio

sources:
  # Package first, then the design bottom up
  - common/lvda_pkg.sv
  - decode/pio_decode.sv
  - execute/buffer_regs.sv
  - execute/interrupt_regs.sv
  - execute/discrete_sampler.sv
  - logic/pio_result.sv
  - logic/lvda_top.sv

  - target: test
    files:
      - verification/lvda_tb.sv
